// File: run.sh
#!/usr/bin/env bash
# Build and run the system-control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module tb_soc \
	-f src.f \
	-o sim_tb_soc

# Keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/sim_tb_soc +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if grep -qx "TESTS PASSED" <<< "$out"; then
	exit 0
fi
exit 1

// File: src.f
verilog/soc_pkg.sv
verilog/soc_if.sv
verilog/reset_gen.sv
verilog/wb_decoder.sv
verilog/csr_bridge.sv
verilog/sysctl.sv
verilog/bus_meter.sv
verilog/activity_led.sv
verilog/soc_top.sv
test/soc_checker.sv
test/tb_soc.sv

// File: test/soc_checker.sv
//--------------------------------------------------
// Protocol checker for the subsystem top level
// Wishbone ack, interrupt pulse and activity LED
//--------------------------------------------------
`timescale 1ns/100ps

module soc_checker (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,
	input logic gpio_irq_i,
	input logic uart_rxd_i,
	input logic rx_led_i
);

	// Number of failed assertions
	int fail_count = 0;

	// Ack lasts exactly one cycle
	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_ack_i |=> !wb_ack_i)
	else begin
		$error("wb_ack_o high on two consecutive cycles");
		fail_count++;
	end

	// Ack only inside an active cycle
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
	else begin
		$error("wb_ack_o high without wb_cyc_i and wb_stb_i");
		fail_count++;
	end

	// Interrupt is a single-cycle pulse
	irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		gpio_irq_i |=> !gpio_irq_i)
	else begin
		$error("gpio_irq_o longer than one cycle");
		fail_count++;
	end

	//--------------------------------------------------
	// Line fell two cycles ago, LED must be lit by now
	//--------------------------------------------------
	led_on_activity: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		($past(uart_rxd_i, 3) && !$past(uart_rxd_i, 2)) |-> rx_led_i)
	else begin
		$error("led_o[0] not lit within 2 cycles of uart_rxd_i going low");
		fail_count++;
	end

endmodule

bind soc_top soc_checker u_soc_checker (
	.sys_clk(sys_clk),
	.sys_rst_i(sys_rst),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_ack_i(wb_ack_o),
	.gpio_irq_i(gpio_irq_o),
	.uart_rxd_i(uart_rxd_i),
	.rx_led_i(led_o[0])
);

// File: test/tb_soc.sv
//--------------------------------------------------
// Testbench for the system-control subsystem
// Wishbone tasks, GPIO, interrupt, reset, meter
//--------------------------------------------------
`timescale 1ns/100ps

module tb_soc;

	logic sys_clk;
	logic arst_n_i;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_ack_o;
	logic [12:0] gpio_in_i;
	logic uart_rxd_i;
	logic [2:0] led_o;
	logic [4:0] btnled_o;
	logic lcd_e_o;
	logic lcd_rs_o;
	logic lcd_rw_o;
	logic [3:0] lcd_d_o;
	logic gpio_irq_o;
	logic periph_rst_n_o;

	int seed;
	int errors;
	int tests_run;
	// Set once a bus access times out
	logic hung;

	soc_top dut (.*);

	// 100 ns period
	always #50 sys_clk = ~sys_clk;

	//--------------------------------------------------
	// Checks and reporting
	//--------------------------------------------------
	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input string what, input logic ok);
		assert (ok) else begin
			$display("** Error at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - start);
	endtask

	// Pins rebuilt into a GPIO word without LED0
	task automatic check_pins(input logic [13:0] word);
		logic [13:0] seen;
		seen = {lcd_d_o, lcd_rw_o, lcd_rs_o, lcd_e_o, btnled_o, led_o[2:1]};
		check_eq("GPIO pins", {18'd0, seen}, {18'd0, word});
	endtask

	//--------------------------------------------------
	// Wishbone master
	//--------------------------------------------------
	// CSR region plus bank and register in address bits 15:2
	function automatic logic [31:0] csr_adr(input logic [3:0] bank, input logic [9:0] idx);
		return {3'b100, 13'd0, bank, idx, 2'b00};
	endfunction

	task automatic bus_access(input logic we, input logic [31:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		rdata = 32'd0;
		if (hung)
			return;
		@(negedge sys_clk);
		wb_adr_i = adr;
		wb_dat_i = wdata;
		wb_we_i = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		cycles = 0;
		// Hold the strobe until ack
		do begin
			@(negedge sys_clk);
			cycles++;
		end while (!wb_ack_o && cycles < 100);
		if (wb_ack_o) begin
			rdata = wb_dat_o;
			// Ack is taken at the next rising edge
			@(negedge sys_clk);
		end else begin
			$display("Timeout: no wb_ack_o for the access to %h", adr);
			hung = 1'b1;
			errors++;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] data);
		bus_access(1'b0, adr, 32'd0, data);
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		bus_access(1'b1, adr, data, ignored);
	endtask

	// Random address outside the CSR region
	function automatic logic [31:0] unmapped_adr(input logic [31:0] rnd);
		if (rnd[31:29] == 3'b100)
			rnd[31] = 1'b0;
		return rnd;
	endfunction

	//--------------------------------------------------
	// Tests
	//--------------------------------------------------
	task automatic test_reset();
		int start;
		int n;
		start = errors;
		repeat (3) @(negedge sys_clk);
		arst_n_i = 1'b1;
		check_true("outputs not idle after reset",
			!wb_ack_o && !gpio_irq_o && !periph_rst_n_o && led_o == 3'd0
			&& btnled_o == 5'd0 && !lcd_e_o && !lcd_rs_o && !lcd_rw_o && lcd_d_o == 4'd0);
		n = 0;
		while (!periph_rst_n_o && n < 20) begin
			@(negedge sys_clk);
			n++;
		end
		if (!periph_rst_n_o) begin
			$display("Timeout: periph_rst_n_o was never released");
			errors++;
		end
		report_test("reset state", start);
	endtask

	task automatic test_unmapped();
		int start;
		logic [31:0] data;
		start = errors;
		repeat (4) begin
			bus_read(unmapped_adr($random(seed)), data);
			check_eq("unmapped read", data, 32'habadface);
		end
		report_test("default responder", start);
	endtask

	task automatic test_sysctl();
		int start;
		logic [31:0] data;
		logic [31:0] rnd;
		logic [13:0] out_word;
		logic [12:0] in_word;
		start = errors;
		bus_read(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_SYSTEM_ID), data);
		check_eq("system id", data, 32'h58343031);
		// Nonzero so the hard reset has something to clear
		rnd = $random(seed);
		out_word = rnd[13:0] | 14'd1;
		bus_write(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT), {18'd0, out_word});
		bus_read(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT), data);
		check_eq("GPIO out readback", data, {18'd0, out_word});
		check_pins(out_word);
		rnd = $random(seed);
		in_word = rnd[12:0];
		@(negedge sys_clk);
		gpio_in_i = in_word;
		// Two-flop input synchronizer
		repeat (3) @(negedge sys_clk);
		bus_read(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IN), data);
		check_eq("GPIO in", data, {19'd0, in_word});
		report_test("sysctl registers", start);
	endtask

	task automatic test_irq();
		int start;
		int k;
		int m;
		int n;
		int pulses;
		start = errors;
		k = {$random(seed)} % 13;
		m = (k + 1) % 13;
		bus_write(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_IRQ_EN), 32'd1 << k);
		@(negedge sys_clk);
		gpio_in_i[k] = ~gpio_in_i[k];
		n = 0;
		while (!gpio_irq_o && n < 10) begin
			@(negedge sys_clk);
			n++;
		end
		check_true("no gpio_irq_o after toggling the enabled bit", gpio_irq_o);
		// Masked bit gets a fixed observation window
		@(negedge sys_clk);
		gpio_in_i[m] = ~gpio_in_i[m];
		pulses = 0;
		repeat (8) begin
			@(negedge sys_clk);
			if (gpio_irq_o)
				pulses++;
		end
		check_true("gpio_irq_o pulsed for a masked bit", pulses == 0);
		report_test("GPIO interrupt", start);
	endtask

	task automatic test_hard_reset();
		int start;
		int low;
		logic [31:0] data;
		start = errors;
		bus_write(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_HARD_RESET), 32'd1);
		low = 0;
		repeat (24) begin
			@(negedge sys_clk);
			if (!periph_rst_n_o)
				low++;
		end
		check_true("periph_rst_n_o dropped by hard reset", low == 0);
		bus_read(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT), data);
		check_eq("GPIO out after hard reset", data, 32'd0);
		bus_read(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_IRQ_EN), data);
		check_eq("IRQ mask after hard reset", data, 32'd0);
		check_pins(14'd0);
		bus_read(csr_adr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_SYSTEM_ID), data);
		check_eq("system id after hard reset", data, 32'h58343031);
		report_test("hard reset", start);
	endtask

	task automatic test_meter_led();
		int start;
		int reads;
		int n;
		logic [31:0] data;
		start = errors;
		reads = 3 + ({$random(seed)} % 4);
		bus_write(csr_adr(soc_pkg::METER_BANK, soc_pkg::REG_METER_CTRL), 32'd1);
		repeat (reads) bus_read(unmapped_adr($random(seed)), data);
		// Enabling write counts but the reading access does not
		bus_read(csr_adr(soc_pkg::METER_BANK, soc_pkg::REG_ACK_COUNT), data);
		check_eq("ack count", data, reads + 1);
		bus_read(csr_adr(soc_pkg::METER_BANK, soc_pkg::REG_STB_COUNT), data);
		check_true("stb count below ack count", data >= reads + 1);
		// Short low burst on the receive line
		@(negedge sys_clk);
		uart_rxd_i = 1'b0;
		repeat (4) @(negedge sys_clk);
		check_true("led_o[0] not lit during line activity", led_o[0]);
		uart_rxd_i = 1'b1;
		n = 0;
		while (led_o[0] && n < 100) begin
			@(negedge sys_clk);
			n++;
		end
		if (led_o[0]) begin
			$display("Timeout: led_o[0] stayed on after the line went idle");
			errors++;
		end
		report_test("bus meter and activity LED", start);
	endtask

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial begin
		sys_clk = 1'b0;
		arst_n_i = 1'b0;
		wb_adr_i = 32'd0;
		wb_dat_i = 32'd0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		gpio_in_i = 13'd0;
		uart_rxd_i = 1'b1;
		seed = 32'hf3c7;
		errors = 0;
		tests_run = 0;
		hung = 1'b0;
		test_reset();
		if (!hung)
			test_unmapped();
		if (!hung)
			test_sysctl();
		if (!hung)
			test_irq();
		if (!hung)
			test_hard_reset();
		if (!hung)
			test_meter_led();
		$display("tests run: %0d, errors: %0d, assertion failures: %0d",
			tests_run, errors, dut.u_soc_checker.fail_count);
		if (errors == 0 && !hung && dut.u_soc_checker.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verilog/activity_led.sv
//--------------------------------------------------
// Serial line activity LED
// Stretches low periods so they stay visible
//--------------------------------------------------
`timescale 1ns/100ps

module activity_led (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic line_i,
	output logic led_o
);

	logic [soc_pkg::STRETCH_W-1:0] stretch_cnt;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			stretch_cnt <= '0;
			led_o <= 1'b0;
		end else begin
			// Reload while line is low, then count down
			if (!line_i)
				stretch_cnt <= '1;
			else if (stretch_cnt != '0)
				stretch_cnt <= stretch_cnt - 1'b1;
			led_o <= (stretch_cnt != '0);
		end
	end

endmodule

// File: verilog/bus_meter.sv
//--------------------------------------------------
// Bus usage meter CSR bank
// Counts strobe and ack cycles on the external bus
//--------------------------------------------------
`timescale 1ns/100ps

module bus_meter (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_if.meter csr,
	input logic wb_stb_i,
	input logic wb_ack_i
);

	logic bank_sel;
	logic meter_en;
	logic [31:0] stb_count;
	logic [31:0] ack_count;

	assign bank_sel = (csr.a.field.bank == soc_pkg::METER_BANK);

	// Control write restarts both counts
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			meter_en <= 1'b0;
			stb_count <= 32'd0;
			ack_count <= 32'd0;
		end else if (csr.we && bank_sel && csr.a.field.idx == soc_pkg::REG_METER_CTRL) begin
			meter_en <= csr.dw[0];
			stb_count <= 32'd0;
			ack_count <= 32'd0;
		end else if (meter_en) begin
			stb_count <= stb_count + {31'd0, wb_stb_i};
			ack_count <= ack_count + {31'd0, wb_ack_i};
		end
	end

	// Read data, zero outside this bank
	always_ff @(posedge sys_clk) begin
		csr.dr_meter <= 32'd0;
		if (bank_sel) begin
			case (csr.a.field.idx)
				soc_pkg::REG_METER_CTRL: csr.dr_meter <= {31'd0, meter_en};
				soc_pkg::REG_STB_COUNT: csr.dr_meter <= stb_count;
				soc_pkg::REG_ACK_COUNT: csr.dr_meter <= ack_count;
				default: csr.dr_meter <= 32'd0;
			endcase
		end
	end

endmodule

// File: verilog/csr_bridge.sv
//--------------------------------------------------
// Wishbone to CSR bridge
// Write acks after two cycles, read after three
//--------------------------------------------------
`timescale 1ns/100ps

module csr_bridge (
	input logic sys_clk,
	input logic sys_rst_i,
	wb_if.slave wb,
	csr_if.bridge csr
);

	logic busy;
	// Cycles left until ack
	logic [1:0] wait_cnt;

	//--------------------------------------------------
	// Control FSM
	//--------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			busy <= 1'b0;
			wait_cnt <= 2'd0;
			wb.ack <= 1'b0;
			csr.we <= 1'b0;
		end else begin
			// Strobe and ack last one cycle
			csr.we <= 1'b0;
			wb.ack <= 1'b0;
			if (!busy) begin
				if (wb.cyc && wb.stb) begin
					busy <= 1'b1;
					// Reads wait for registered slave data
					wait_cnt <= wb.we ? 2'd2 : 2'd3;
					csr.we <= wb.we;
				end
			end else if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
				wb.ack <= (wait_cnt == 2'd1);
			end else begin
				// Ack cycle done, master has dropped stb
				busy <= 1'b0;
			end
		end
	end

	//--------------------------------------------------
	// Address, write data and read data
	//--------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!busy && wb.cyc && wb.stb) begin
			csr.a.raw <= wb.adr[soc_pkg::CSR_ADDR_W+1:2];
			csr.dw <= wb.dat_w;
		end
		// Slaves drive zero outside their bank
		if (busy && wait_cnt == 2'd1)
			wb.dat_r <= csr.dr_sysctl | csr.dr_meter;
	end

endmodule

// File: verilog/reset_gen.sv
//--------------------------------------------------
// Reset generator
// Debounced system reset with hard-reset retrigger
// and a separately counted peripheral reset
//--------------------------------------------------
`timescale 1ns/100ps

module reset_gen (
	input logic sys_clk,
	input logic arst_n_i,
	input logic hard_reset_i,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	logic rst_s1;
	logic rst_s2;
	logic [soc_pkg::DEBOUNCE_W-1:0] debounce_cnt;
	logic [soc_pkg::PERIPH_RST_W-1:0] periph_cnt;

	// Assert at once, release through two flops
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_s1 <= 1'b0;
			rst_s2 <= 1'b0;
		end else begin
			rst_s1 <= 1'b1;
			rst_s2 <= rst_s1;
		end
	end

	// Debounce, reloaded by pin or software
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			debounce_cnt <= '1;
			sys_rst_o <= 1'b1;
		end else begin
			if (!rst_s2 || hard_reset_i)
				debounce_cnt <= '1;
			else if (debounce_cnt != '0)
				debounce_cnt <= debounce_cnt - 1'b1;
			sys_rst_o <= (debounce_cnt != '0);
		end
	end

	// Peripheral reset, top bit ends the count
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			periph_cnt <= '0;
		else if (!rst_s2)
			periph_cnt <= '0;
		else if (!periph_cnt[soc_pkg::PERIPH_RST_W-1])
			periph_cnt <= periph_cnt + 1'b1;
	end

	assign periph_rst_n_o = periph_cnt[soc_pkg::PERIPH_RST_W-1];

endmodule

// File: verilog/soc_if.sv
//--------------------------------------------------
// Internal buses of the system-control subsystem
// Wishbone segment to the bridge and the CSR bus
//--------------------------------------------------
`timescale 1ns/100ps

// Wishbone classic segment, decoder to CSR bridge
interface wb_if;
	logic cyc;
	logic stb;
	logic we;
	logic [31:0] adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	modport slave (
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);
endinterface

// CSR bus, one read data line per slave bank
interface csr_if;
	soc_pkg::csr_addr_u a;
	logic we;
	logic [31:0] dw;
	logic [31:0] dr_sysctl;
	logic [31:0] dr_meter;

	modport bridge (
		output a, we, dw,
		input dr_sysctl, dr_meter
	);

	modport sysctl (
		input a, we, dw,
		output dr_sysctl
	);

	modport meter (
		input a, we, dw,
		output dr_meter
	);
endinterface

// File: verilog/soc_pkg.sv
//--------------------------------------------------
// SoC system-control package
// Address map, CSR banks, register indices, widths
//--------------------------------------------------
package soc_pkg;

	// Top address bits pick the bus region
	localparam int REGION_W = 3;
	localparam logic [REGION_W-1:0] CSR_REGION = 3'b100;
	// Marker word from the default responder
	localparam logic [31:0] UNMAPPED_DATA = 32'habadface;

	// CSR address split into bank and register
	localparam int CSR_ADDR_W = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = 10;
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK = 4'h1;
	localparam logic [CSR_BANK_W-1:0] METER_BANK = 4'ha;

	// System controller registers
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_IRQ_EN = 10'd2;
	localparam logic [CSR_REG_W-1:0] REG_SYSTEM_ID = 10'd3;
	localparam logic [CSR_REG_W-1:0] REG_HARD_RESET = 10'd4;

	// Bus meter registers
	localparam logic [CSR_REG_W-1:0] REG_METER_CTRL = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_STB_COUNT = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_ACK_COUNT = 10'd2;

	// Board identifier, X401
	localparam logic [31:0] SYSTEM_ID = 32'h58343031;
	localparam int GPIO_IN_W = 13;
	localparam int GPIO_OUT_W = 14;

	// Counter widths
	localparam int DEBOUNCE_W = 4;
	localparam int PERIPH_RST_W = 3;
	localparam int STRETCH_W = 6;

	typedef struct packed {
		logic [CSR_BANK_W-1:0] bank;
		logic [CSR_REG_W-1:0] idx;
	} csr_field_t;

	// Raw from the bridge, bank/register for the slaves
	typedef union packed {
		logic [CSR_ADDR_W-1:0] raw;
		csr_field_t field;
	} csr_addr_u;

endpackage

// File: verilog/soc_top.sv
//--------------------------------------------------
// System-control subsystem top level
// Reset, bus decode, CSR banks and board pin map
//--------------------------------------------------
`timescale 1ns/100ps

module soc_top (
	input logic sys_clk,
	input logic arst_n_i,
	// Wishbone slave port
	input logic [31:0] wb_adr_i,
	input logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic wb_ack_o,
	// DIP switches and buttons
	input logic [soc_pkg::GPIO_IN_W-1:0] gpio_in_i,
	input logic uart_rxd_i,
	// Board outputs
	output logic [2:0] led_o,
	output logic [4:0] btnled_o,
	output logic lcd_e_o,
	output logic lcd_rs_o,
	output logic lcd_rw_o,
	output logic [3:0] lcd_d_o,
	output logic gpio_irq_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	logic hard_reset;
	logic rx_led;
	logic [soc_pkg::GPIO_OUT_W-1:0] gpio_out;

	wb_if csr_wb ();
	csr_if csr_bus ();

	//--------------------------------------------------
	// Reset generation
	//--------------------------------------------------
	reset_gen u_reset_gen (
		.sys_clk(sys_clk),
		.arst_n_i(arst_n_i),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst),
		.periph_rst_n_o(periph_rst_n_o)
	);

	//--------------------------------------------------
	// External bus decode and CSR bridge
	//--------------------------------------------------
	wb_decoder u_wb_decoder (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.csr_bus(csr_wb.master)
	);

	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb(csr_wb.slave),
		.csr(csr_bus.bridge)
	);

	//--------------------------------------------------
	// CSR banks
	//--------------------------------------------------
	sysctl u_sysctl (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.sysctl),
		.gpio_in_i(gpio_in_i),
		.gpio_out_o(gpio_out),
		.gpio_irq_o(gpio_irq_o),
		.hard_reset_o(hard_reset)
	);

	// Watches the external bus handshake
	bus_meter u_bus_meter (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.meter),
		.wb_stb_i(wb_stb_i),
		.wb_ack_i(wb_ack_o)
	);

	activity_led u_rx_led (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.line_i(uart_rxd_i),
		.led_o(rx_led)
	);

	// LED0 shows receive activity, the rest is GPIO
	assign led_o = {gpio_out[1:0], rx_led};
	assign btnled_o = gpio_out[6:2];
	// Character LCD control and nibble bus
	assign lcd_e_o = gpio_out[7];
	assign lcd_rs_o = gpio_out[8];
	assign lcd_rw_o = gpio_out[9];
	assign lcd_d_o = gpio_out[13:10];

endmodule

// File: verilog/sysctl.sv
//--------------------------------------------------
// System controller CSR bank
// GPIO in/out, change interrupt, board ID and
// software hard reset
//--------------------------------------------------
`timescale 1ns/100ps

module sysctl (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_if.sysctl csr,
	input logic [soc_pkg::GPIO_IN_W-1:0] gpio_in_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_out_o,
	output logic gpio_irq_o,
	output logic hard_reset_o
);

	logic bank_sel;
	logic [soc_pkg::GPIO_IN_W-1:0] gpio_s1;
	logic [soc_pkg::GPIO_IN_W-1:0] gpio_s2;
	logic [soc_pkg::GPIO_IN_W-1:0] gpio_prev;
	logic [soc_pkg::GPIO_IN_W-1:0] irq_en;

	assign bank_sel = (csr.a.field.bank == soc_pkg::SYSCTL_BANK);

	//--------------------------------------------------
	// Input synchronizer and change interrupt
	//--------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_s1 <= '0;
			gpio_s2 <= '0;
			gpio_prev <= '0;
			gpio_irq_o <= 1'b0;
		end else begin
			gpio_s1 <= gpio_in_i;
			gpio_s2 <= gpio_s1;
			gpio_prev <= gpio_s2;
			// Any enabled bit that changed
			gpio_irq_o <= |((gpio_s2 ^ gpio_prev) & irq_en);
		end
	end

	//--------------------------------------------------
	// Register writes
	//--------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			irq_en <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= 1'b0;
			if (csr.we && bank_sel) begin
				case (csr.a.field.idx)
					soc_pkg::REG_GPIO_OUT: gpio_out_o <= csr.dw[soc_pkg::GPIO_OUT_W-1:0];
					soc_pkg::REG_IRQ_EN: irq_en <= csr.dw[soc_pkg::GPIO_IN_W-1:0];
					// Bit 0 requests a reset pulse
					soc_pkg::REG_HARD_RESET: hard_reset_o <= csr.dw[0];
					default: ;
				endcase
			end
		end
	end

	//--------------------------------------------------
	// Registered read data
	//--------------------------------------------------
	always_ff @(posedge sys_clk) begin
		csr.dr_sysctl <= 32'd0;
		if (bank_sel) begin
			case (csr.a.field.idx)
				soc_pkg::REG_GPIO_IN:
					csr.dr_sysctl <= {{(32-soc_pkg::GPIO_IN_W){1'b0}}, gpio_s2};
				soc_pkg::REG_GPIO_OUT:
					csr.dr_sysctl <= {{(32-soc_pkg::GPIO_OUT_W){1'b0}}, gpio_out_o};
				soc_pkg::REG_IRQ_EN:
					csr.dr_sysctl <= {{(32-soc_pkg::GPIO_IN_W){1'b0}}, irq_en};
				soc_pkg::REG_SYSTEM_ID:
					csr.dr_sysctl <= soc_pkg::SYSTEM_ID;
				default:
					csr.dr_sysctl <= 32'd0;
			endcase
		end
	end

endmodule

// File: verilog/wb_decoder.sv
//--------------------------------------------------
// External Wishbone region decoder
// CSR region to the bridge, all else to a
// default responder returning a marker word
//--------------------------------------------------
`timescale 1ns/100ps

module wb_decoder (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic [31:0] wb_adr_i,
	input logic [31:0] wb_dat_i,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	wb_if.master csr_bus
);

	logic [soc_pkg::REGION_W-1:0] region;
	logic csr_sel;
	logic dflt_ack;

	// Region from the top address bits
	assign region = wb_adr_i[31 -: soc_pkg::REGION_W];
	assign csr_sel = (region == soc_pkg::CSR_REGION);

	// CSR segment only sees its own cycles
	assign csr_bus.cyc = wb_cyc_i & csr_sel;
	assign csr_bus.stb = wb_stb_i & csr_sel;
	assign csr_bus.we = wb_we_i;
	assign csr_bus.adr = wb_adr_i;
	assign csr_bus.dat_w = wb_dat_i;

	//--------------------------------------------------
	// Default responder
	//--------------------------------------------------
	// One-cycle ack, never back to back
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			dflt_ack <= 1'b0;
		else
			dflt_ack <= wb_cyc_i & wb_stb_i & ~csr_sel & ~dflt_ack;
	end

	// Return path by region
	assign wb_dat_o = csr_sel ? csr_bus.dat_r : soc_pkg::UNMAPPED_DATA;
	assign wb_ack_o = csr_sel ? csr_bus.ack : dflt_ack;

endmodule
